/* verilog/standby_pkg.sv */
// Shared widths, bit counts, FSM encodings and address byte type for the standby target
package standby_pkg;

  localparam int unsigned ByteWidth = 8;
  localparam int unsigned AddrWidth = 7;
  localparam int unsigned BitCntWidth = 4;
  localparam int unsigned SyncStages = 2;

  // Data bits per byte as seen by the bit counters
  localparam logic [BitCntWidth-1:0] BitsPerByte = BitCntWidth'(ByteWidth);

  localparam int unsigned StateWidth = 3;

  // I2C engine states
  localparam logic [StateWidth-1:0] I2cIdle = 3'd0;
  localparam logic [StateWidth-1:0] I2cAddr = 3'd1;
  localparam logic [StateWidth-1:0] I2cAddrAck = 3'd2;
  localparam logic [StateWidth-1:0] I2cWrData = 3'd3;
  localparam logic [StateWidth-1:0] I2cDataAck = 3'd4;
  localparam logic [StateWidth-1:0] I2cRdData = 3'd5;
  localparam logic [StateWidth-1:0] I2cHostAck = 3'd6;

  // I3C engine states
  localparam logic [StateWidth-1:0] I3cIdle = 3'd0;
  localparam logic [StateWidth-1:0] I3cAddr = 3'd1;
  localparam logic [StateWidth-1:0] I3cAddrAck = 3'd2;
  localparam logic [StateWidth-1:0] I3cData = 3'd3;

  // First byte after START, raw for reporting or split for matching
  typedef union packed {
    logic [ByteWidth-1:0] raw;
    struct packed {
      logic [AddrWidth-1:0] addr;
      logic rnw;
    } fields;
  } addr_byte_u;

endpackage

/* verilog/bus_monitor.sv */
// Bus monitor: synchronizes SCL/SDA and strobes START, STOP and SCL edges for both engines
`timescale 1ns/1ps

module bus_monitor (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic scl_i,
  input  logic sda_i,
  output logic start_o,
  output logic stop_o,
  output logic scl_rise_o,
  output logic scl_fall_o,
  output logic sda_o
);

  logic [standby_pkg::SyncStages-1:0] scl_sync_q;
  logic [standby_pkg::SyncStages-1:0] sda_sync_q;
  logic scl_prev_q;
  logic sda_prev_q;
  logic scl_s;
  logic sda_s;

  assign scl_s = scl_sync_q[standby_pkg::SyncStages-1];
  assign sda_s = sda_sync_q[standby_pkg::SyncStages-1];

  // Idle bus is high on both lines
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q <= '1;
      sda_sync_q <= '1;
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
    end else begin
      scl_sync_q <= {scl_sync_q[standby_pkg::SyncStages-2:0], scl_i};
      sda_sync_q <= {sda_sync_q[standby_pkg::SyncStages-2:0], sda_i};
      scl_prev_q <= scl_s;
      sda_prev_q <= sda_s;
    end
  end

  // SDA moving while SCL stays high marks a bus condition
  assign start_o = scl_s && scl_prev_q && sda_prev_q && !sda_s;
  assign stop_o = scl_s && scl_prev_q && !sda_prev_q && sda_s;

  assign scl_rise_o = scl_s && !scl_prev_q;
  assign scl_fall_o = !scl_s && scl_prev_q;

  assign sda_o = sda_s;

endmodule

/* verilog/i2c_target.sv */
// I2C target engine: matches the static address, receives writes into RX queue, reads TX queue
`timescale 1ns/1ps

module i2c_target (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic enable_i,
  input  logic start_i,
  input  logic stop_i,
  input  logic scl_rise_i,
  input  logic scl_fall_i,
  input  logic sda_i,
  input  logic [standby_pkg::AddrWidth-1:0] target_sta_addr_i,
  input  logic rx_queue_full_i,
  input  logic rx_queue_wready_i,
  input  logic tx_queue_rvalid_i,
  input  logic [standby_pkg::ByteWidth-1:0] tx_queue_rdata_i,
  output logic sda_pull_o,
  output logic rx_queue_wvalid_o,
  output logic [standby_pkg::ByteWidth-1:0] rx_queue_wdata_o,
  output logic tx_queue_rready_o,
  output standby_pkg::addr_byte_u bus_addr_o,
  output logic bus_addr_valid_o,
  output logic tx_host_nack_o,
  output logic xfer_active_o
);

  logic [standby_pkg::StateWidth-1:0] state_q;
  logic [standby_pkg::BitCntWidth-1:0] bit_cnt_q;
  logic [standby_pkg::ByteWidth-1:0] shift_q;
  logic ack_q;
  logic addr_match;
  logic rx_free;
  logic tx_load;
  logic [standby_pkg::ByteWidth-1:0] tx_byte;

  assign addr_match = bus_addr_o.fields.addr == target_sta_addr_i;
  assign rx_free = !rx_queue_full_i && !rx_queue_wvalid_o;

  // Next read byte is fetched after the address ACK or a host ACK
  assign tx_load = scl_fall_i &&
                   ((state_q == standby_pkg::I2cAddrAck && bus_addr_o.fields.rnw) ||
                    (state_q == standby_pkg::I2cHostAck && ack_q));
  assign tx_byte = tx_queue_rvalid_i ? tx_queue_rdata_i : '1;
  assign tx_queue_rready_o = tx_load;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= standby_pkg::I2cIdle;
      bit_cnt_q <= '0;
      shift_q <= '0;
      ack_q <= 1'b0;
      sda_pull_o <= 1'b0;
      rx_queue_wvalid_o <= 1'b0;
      rx_queue_wdata_o <= '0;
      bus_addr_o <= '0;
      bus_addr_valid_o <= 1'b0;
      tx_host_nack_o <= 1'b0;
      xfer_active_o <= 1'b0;
    end else if (!enable_i) begin
      state_q <= standby_pkg::I2cIdle;
      bit_cnt_q <= '0;
      shift_q <= '0;
      ack_q <= 1'b0;
      sda_pull_o <= 1'b0;
      rx_queue_wvalid_o <= 1'b0;
      rx_queue_wdata_o <= '0;
      bus_addr_o <= '0;
      bus_addr_valid_o <= 1'b0;
      tx_host_nack_o <= 1'b0;
      xfer_active_o <= 1'b0;
    end else begin
      bus_addr_valid_o <= 1'b0;
      tx_host_nack_o <= 1'b0;
      if (rx_queue_wvalid_o && rx_queue_wready_i) begin
        rx_queue_wvalid_o <= 1'b0;
      end

      case (state_q)
        standby_pkg::I2cAddr: begin
          if (scl_rise_i) begin
            shift_q <= {shift_q[standby_pkg::ByteWidth-2:0], sda_i};
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == standby_pkg::BitsPerByte - 1'b1) begin
              bus_addr_o.raw <= {shift_q[standby_pkg::ByteWidth-2:0], sda_i};
              bus_addr_valid_o <= 1'b1;
            end
          end else if (scl_fall_i && bit_cnt_q == standby_pkg::BitsPerByte) begin
            if (addr_match) begin
              sda_pull_o <= 1'b1;
              xfer_active_o <= 1'b1;
              state_q <= standby_pkg::I2cAddrAck;
            end else begin
              state_q <= standby_pkg::I2cIdle;
            end
          end
        end
        standby_pkg::I2cAddrAck: begin
          // Reads override this through tx_load below
          if (scl_fall_i) begin
            sda_pull_o <= 1'b0;
            bit_cnt_q <= '0;
            state_q <= standby_pkg::I2cWrData;
          end
        end
        standby_pkg::I2cWrData: begin
          if (scl_rise_i) begin
            shift_q <= {shift_q[standby_pkg::ByteWidth-2:0], sda_i};
            bit_cnt_q <= bit_cnt_q + 1'b1;
          end else if (scl_fall_i && bit_cnt_q == standby_pkg::BitsPerByte) begin
            ack_q <= rx_free;
            sda_pull_o <= rx_free;
            state_q <= standby_pkg::I2cDataAck;
          end
        end
        standby_pkg::I2cDataAck: begin
          if (scl_rise_i && ack_q) begin
            rx_queue_wvalid_o <= 1'b1;
            rx_queue_wdata_o <= shift_q;
          end else if (scl_fall_i) begin
            sda_pull_o <= 1'b0;
            bit_cnt_q <= '0;
            state_q <= standby_pkg::I2cWrData;
          end
        end
        standby_pkg::I2cRdData: begin
          if (scl_rise_i) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
          end else if (scl_fall_i) begin
            if (bit_cnt_q == standby_pkg::BitsPerByte) begin
              sda_pull_o <= 1'b0;
              state_q <= standby_pkg::I2cHostAck;
            end else begin
              shift_q <= {shift_q[standby_pkg::ByteWidth-2:0], 1'b1};
              sda_pull_o <= !shift_q[standby_pkg::ByteWidth-2];
            end
          end
        end
        standby_pkg::I2cHostAck: begin
          if (scl_rise_i) begin
            ack_q <= !sda_i;
            tx_host_nack_o <= sda_i;
          end else if (scl_fall_i) begin
            state_q <= standby_pkg::I2cIdle;
          end
        end
        default: ;
      endcase

      if (tx_load) begin
        shift_q <= tx_byte;
        sda_pull_o <= !tx_byte[standby_pkg::ByteWidth-1];
        bit_cnt_q <= '0;
        state_q <= standby_pkg::I2cRdData;
      end

      // Bus conditions restart the FSM from any state
      if (start_i) begin
        state_q <= standby_pkg::I2cAddr;
        bit_cnt_q <= '0;
        sda_pull_o <= 1'b0;
        xfer_active_o <= 1'b0;
      end else if (stop_i) begin
        state_q <= standby_pkg::I2cIdle;
        sda_pull_o <= 1'b0;
        xfer_active_o <= 1'b0;
      end
    end
  end

endmodule

/* verilog/i3c_target.sv */
// I3C private-write engine: dynamic address match, T-bit parity check and sticky parity error
`timescale 1ns/1ps

module i3c_target (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic enable_i,
  input  logic start_i,
  input  logic stop_i,
  input  logic scl_rise_i,
  input  logic scl_fall_i,
  input  logic sda_i,
  input  logic [standby_pkg::AddrWidth-1:0] target_dyn_addr_i,
  input  logic target_dyn_addr_valid_i,
  input  logic rx_queue_full_i,
  input  logic rx_queue_wready_i,
  input  logic err_clr_i,
  output logic sda_pull_o,
  output logic rx_queue_wvalid_o,
  output logic [standby_pkg::ByteWidth-1:0] rx_queue_wdata_o,
  output standby_pkg::addr_byte_u bus_addr_o,
  output logic bus_addr_valid_o,
  output logic err_o,
  output logic xfer_active_o
);

  logic [standby_pkg::StateWidth-1:0] state_q;
  logic [standby_pkg::BitCntWidth-1:0] bit_cnt_q;
  logic [standby_pkg::ByteWidth-1:0] shift_q;
  logic addr_match;
  logic rx_free;
  logic parity_ok;

  // Only private writes are served, reads get a NACK
  assign addr_match = target_dyn_addr_valid_i && !bus_addr_o.fields.rnw &&
                      bus_addr_o.fields.addr == target_dyn_addr_i;
  assign rx_free = !rx_queue_full_i && !rx_queue_wvalid_o;

  // Data byte plus T-bit must hold an odd number of ones
  assign parity_ok = ^{shift_q, sda_i};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= standby_pkg::I3cIdle;
      bit_cnt_q <= '0;
      shift_q <= '0;
      sda_pull_o <= 1'b0;
      rx_queue_wvalid_o <= 1'b0;
      rx_queue_wdata_o <= '0;
      bus_addr_o <= '0;
      bus_addr_valid_o <= 1'b0;
      err_o <= 1'b0;
      xfer_active_o <= 1'b0;
    end else if (!enable_i) begin
      state_q <= standby_pkg::I3cIdle;
      bit_cnt_q <= '0;
      shift_q <= '0;
      sda_pull_o <= 1'b0;
      rx_queue_wvalid_o <= 1'b0;
      rx_queue_wdata_o <= '0;
      bus_addr_o <= '0;
      bus_addr_valid_o <= 1'b0;
      err_o <= 1'b0;
      xfer_active_o <= 1'b0;
    end else begin
      bus_addr_valid_o <= 1'b0;
      if (rx_queue_wvalid_o && rx_queue_wready_i) begin
        rx_queue_wvalid_o <= 1'b0;
      end

      case (state_q)
        standby_pkg::I3cAddr: begin
          if (scl_rise_i) begin
            shift_q <= {shift_q[standby_pkg::ByteWidth-2:0], sda_i};
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == standby_pkg::BitsPerByte - 1'b1) begin
              bus_addr_o.raw <= {shift_q[standby_pkg::ByteWidth-2:0], sda_i};
              bus_addr_valid_o <= 1'b1;
            end
          end else if (scl_fall_i && bit_cnt_q == standby_pkg::BitsPerByte) begin
            if (addr_match) begin
              sda_pull_o <= 1'b1;
              xfer_active_o <= 1'b1;
              state_q <= standby_pkg::I3cAddrAck;
            end else begin
              state_q <= standby_pkg::I3cIdle;
            end
          end
        end
        standby_pkg::I3cAddrAck: begin
          if (scl_fall_i) begin
            sda_pull_o <= 1'b0;
            bit_cnt_q <= '0;
            state_q <= standby_pkg::I3cData;
          end
        end
        standby_pkg::I3cData: begin
          if (scl_rise_i) begin
            if (bit_cnt_q == standby_pkg::BitsPerByte) begin
              // T-bit sampled, frame complete
              bit_cnt_q <= '0;
              if (rx_free) begin
                if (parity_ok) begin
                  rx_queue_wvalid_o <= 1'b1;
                  rx_queue_wdata_o <= shift_q;
                end else begin
                  err_o <= 1'b1;
                end
              end
            end else begin
              shift_q <= {shift_q[standby_pkg::ByteWidth-2:0], sda_i};
              bit_cnt_q <= bit_cnt_q + 1'b1;
            end
          end
        end
        default: ;
      endcase

      if (err_clr_i) begin
        err_o <= 1'b0;
      end

      if (start_i) begin
        state_q <= standby_pkg::I3cAddr;
        bit_cnt_q <= '0;
        sda_pull_o <= 1'b0;
        xfer_active_o <= 1'b0;
      end else if (stop_i) begin
        state_q <= standby_pkg::I3cIdle;
        sda_pull_o <= 1'b0;
        xfer_active_o <= 1'b0;
      end
    end
  end

endmodule

/* verilog/controller_standby.sv */
// Standby target top level: bus monitor plus I2C and I3C engines selected by the mode input
`timescale 1ns/1ps

module controller_standby (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic scl_i,
  input  logic sda_i,
  input  logic i3c_standby_en_i,
  input  logic [standby_pkg::AddrWidth-1:0] target_sta_addr_i,
  input  logic [standby_pkg::AddrWidth-1:0] target_dyn_addr_i,
  input  logic target_dyn_addr_valid_i,
  input  logic rx_queue_full_i,
  input  logic rx_queue_wready_i,
  input  logic tx_queue_rvalid_i,
  input  logic [standby_pkg::ByteWidth-1:0] tx_queue_rdata_i,
  input  logic err_clr_i,
  output logic sda_o,
  output logic rx_queue_wvalid_o,
  output logic [standby_pkg::ByteWidth-1:0] rx_queue_wdata_o,
  output logic tx_queue_rready_o,
  output logic bus_start_o,
  output logic bus_rstart_o,
  output logic bus_stop_o,
  output logic [standby_pkg::ByteWidth-1:0] bus_addr_o,
  output logic bus_addr_valid_o,
  output logic tx_host_nack_o,
  output logic err_o,
  output logic xfer_in_progress_o
);

  logic mon_start;
  logic mon_stop;
  logic mon_scl_rise;
  logic mon_scl_fall;
  logic mon_sda;

  logic i2c_en;
  logic i3c_en;

  logic i2c_sda_pull;
  logic i2c_rx_wvalid;
  logic [standby_pkg::ByteWidth-1:0] i2c_rx_wdata;
  standby_pkg::addr_byte_u i2c_bus_addr;
  logic i2c_bus_addr_valid;
  logic i2c_xfer;

  logic i3c_sda_pull;
  logic i3c_rx_wvalid;
  logic [standby_pkg::ByteWidth-1:0] i3c_rx_wdata;
  standby_pkg::addr_byte_u i3c_bus_addr;
  logic i3c_bus_addr_valid;
  logic i3c_xfer;

  // Mode only changes on an idle bus, so exactly one engine is live
  assign i3c_en = i3c_standby_en_i;
  assign i2c_en = !i3c_standby_en_i;

  bus_monitor xbus_monitor (
    .clk_i(clk_i),
    .rst_ni(rst_ni),
    .scl_i(scl_i),
    .sda_i(sda_i),
    .start_o(mon_start),
    .stop_o(mon_stop),
    .scl_rise_o(mon_scl_rise),
    .scl_fall_o(mon_scl_fall),
    .sda_o(mon_sda)
  );

  i2c_target xi2c_target (
    .clk_i(clk_i),
    .rst_ni(rst_ni),
    .enable_i(i2c_en),
    .start_i(mon_start),
    .stop_i(mon_stop),
    .scl_rise_i(mon_scl_rise),
    .scl_fall_i(mon_scl_fall),
    .sda_i(mon_sda),
    .target_sta_addr_i(target_sta_addr_i),
    .rx_queue_full_i(rx_queue_full_i),
    .rx_queue_wready_i(rx_queue_wready_i),
    .tx_queue_rvalid_i(tx_queue_rvalid_i),
    .tx_queue_rdata_i(tx_queue_rdata_i),
    .sda_pull_o(i2c_sda_pull),
    .rx_queue_wvalid_o(i2c_rx_wvalid),
    .rx_queue_wdata_o(i2c_rx_wdata),
    .tx_queue_rready_o(tx_queue_rready_o),
    .bus_addr_o(i2c_bus_addr),
    .bus_addr_valid_o(i2c_bus_addr_valid),
    .tx_host_nack_o(tx_host_nack_o),
    .xfer_active_o(i2c_xfer)
  );

  i3c_target xi3c_target (
    .clk_i(clk_i),
    .rst_ni(rst_ni),
    .enable_i(i3c_en),
    .start_i(mon_start),
    .stop_i(mon_stop),
    .scl_rise_i(mon_scl_rise),
    .scl_fall_i(mon_scl_fall),
    .sda_i(mon_sda),
    .target_dyn_addr_i(target_dyn_addr_i),
    .target_dyn_addr_valid_i(target_dyn_addr_valid_i),
    .rx_queue_full_i(rx_queue_full_i),
    .rx_queue_wready_i(rx_queue_wready_i),
    .err_clr_i(err_clr_i),
    .sda_pull_o(i3c_sda_pull),
    .rx_queue_wvalid_o(i3c_rx_wvalid),
    .rx_queue_wdata_o(i3c_rx_wdata),
    .bus_addr_o(i3c_bus_addr),
    .bus_addr_valid_o(i3c_bus_addr_valid),
    .err_o(err_o),
    .xfer_active_o(i3c_xfer)
  );

  // Disabled engine drives zeros, so OR merges cleanly
  assign sda_o = i2c_sda_pull | i3c_sda_pull;
  assign rx_queue_wvalid_o = i2c_rx_wvalid | i3c_rx_wvalid;
  assign rx_queue_wdata_o = i2c_rx_wdata | i3c_rx_wdata;
  assign bus_addr_o = i2c_bus_addr.raw | i3c_bus_addr.raw;
  assign bus_addr_valid_o = i2c_bus_addr_valid | i3c_bus_addr_valid;
  assign xfer_in_progress_o = i2c_xfer | i3c_xfer;

  // START inside an open transfer is a repeated START
  assign bus_start_o = mon_start && !xfer_in_progress_o;
  assign bus_rstart_o = mon_start && xfer_in_progress_o;
  assign bus_stop_o = mon_stop;

endmodule

/* dv/controller_standby_assertions.sv */
// Concurrent checks on the standby target top level, attached by bind from the testbench
`timescale 1ns/1ps

module controller_standby_assertions (
  input logic clk_i,
  input logic rst_ni,
  input logic i3c_standby_en_i,
  input logic rx_queue_wvalid_i,
  input logic rx_queue_wready_i,
  input logic [7:0] rx_queue_wdata_i,
  input logic sda_pull_i,
  input logic scl_rise_i,
  input logic scl_fall_i,
  input logic err_i
);

  logic scl_low_q;

  // Synchronized SCL level rebuilt from the monitor strobes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_low_q <= 1'b0;
    end else if (scl_fall_i) begin
      scl_low_q <= 1'b1;
    end else if (scl_rise_i) begin
      scl_low_q <= 1'b0;
    end
  end

  rx_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_queue_wvalid_i && !rx_queue_wready_i |=> rx_queue_wvalid_i && $stable(rx_queue_wdata_i))
    else $error("RX valid or data changed before ready");

  // Releasing the line is allowed at any time
  sda_pull_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(sda_pull_i) |-> scl_low_q)
    else $error("SDA pull asserted while SCL was high");

  err_mode_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(err_i) |-> i3c_standby_en_i)
    else $error("Parity error raised outside I3C mode");

endmodule

/* dv/tb_controller_standby.sv */
// Testbench for the standby target that drives I2C and I3C transfers and checks queues and bus events
`timescale 1ns/1ps

module tb_controller_standby;

  localparam int unsigned ClkPeriod = 10;
  localparam int unsigned HalfScl = 8;
  localparam int unsigned SclPeriod = 2 * HalfScl * ClkPeriod;
  localparam logic [6:0] StaAddr = 7'h2a;
  localparam logic [6:0] DynAddr = 7'h35;
  // 21 address and data bytes of nine bits plus 13 bus conditions
  localparam int unsigned TotalBits = 9 * 21 + 13;

  logic clk_i;
  logic rst_ni;
  logic scl;
  logic sda_m;
  logic sda_line;
  logic i3c_mode;
  logic dyn_addr_valid;
  logic rx_full;
  logic rx_wready;
  logic tx_rvalid;
  logic [7:0] tx_rdata;
  logic err_clr;

  logic sda_pull;
  logic rx_wvalid;
  logic [7:0] rx_wdata;
  logic tx_rready;
  logic bus_start;
  logic bus_rstart;
  logic bus_stop;
  logic [7:0] bus_addr;
  logic bus_addr_valid;
  logic tx_host_nack;
  logic err;
  logic xfer;

  logic [7:0] exp_bytes[$];
  logic [7:0] tx_model[$];
  logic [8:0] frame_q[$];
  int unsigned n_start, n_rstart, n_stop, n_addr_valid, n_host_nack;
  int unsigned exp_start, exp_rstart, exp_stop, exp_addr_valid, exp_host_nack;
  logic [7:0] last_addr;
  logic xfer_open;
  logic exp_err;

  // Open drain bus where the DUT only pulls low
  assign sda_line = sda_m && !sda_pull;

  controller_standby uut (
    .clk_i(clk_i),
    .rst_ni(rst_ni),
    .scl_i(scl),
    .sda_i(sda_line),
    .i3c_standby_en_i(i3c_mode),
    .target_sta_addr_i(StaAddr),
    .target_dyn_addr_i(DynAddr),
    .target_dyn_addr_valid_i(dyn_addr_valid),
    .rx_queue_full_i(rx_full),
    .rx_queue_wready_i(rx_wready),
    .tx_queue_rvalid_i(tx_rvalid),
    .tx_queue_rdata_i(tx_rdata),
    .err_clr_i(err_clr),
    .sda_o(sda_pull),
    .rx_queue_wvalid_o(rx_wvalid),
    .rx_queue_wdata_o(rx_wdata),
    .tx_queue_rready_o(tx_rready),
    .bus_start_o(bus_start),
    .bus_rstart_o(bus_rstart),
    .bus_stop_o(bus_stop),
    .bus_addr_o(bus_addr),
    .bus_addr_valid_o(bus_addr_valid),
    .tx_host_nack_o(tx_host_nack),
    .err_o(err),
    .xfer_in_progress_o(xfer)
  );

  bind controller_standby controller_standby_assertions u_assertions (
    .clk_i(clk_i),
    .rst_ni(rst_ni),
    .i3c_standby_en_i(i3c_standby_en_i),
    .rx_queue_wvalid_i(rx_queue_wvalid_o),
    .rx_queue_wready_i(rx_queue_wready_i),
    .rx_queue_wdata_i(rx_queue_wdata_o),
    .sda_pull_i(sda_o),
    .scl_rise_i(mon_scl_rise),
    .scl_fall_i(mon_scl_fall),
    .err_i(err_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("TB FAILED");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic compare_value(input string name, input int unsigned got,
                               input int unsigned expected);
    assert (got == expected)
      else report_failure($sformatf("[ERROR] %0t %s expected 0x%0h got 0x%0h",
                                    $time, name, expected, got));
  endtask

  function automatic logic expected_addr_ack(input logic mode, input logic [7:0] addr_byte);
    if (mode) begin
      return dyn_addr_valid && addr_byte[7:1] == DynAddr && !addr_byte[0];
    end else begin
      return addr_byte[7:1] == StaAddr;
    end
  endfunction

  // Result is {accepted, acked, parity_err} for one frame {byte, T-bit}
  function automatic logic [2:0] expected_frame(input logic mode, input logic [7:0] addr_byte,
                                                input logic full, input logic [8:0] frame);
    logic take;
    take = expected_addr_ack(mode, addr_byte) && !addr_byte[0] && !full;
    if (mode) begin
      return {take && ^frame, 1'b0, take && !(^frame)};
    end else begin
      return {take, take, 1'b0};
    end
  endfunction

  task automatic wait_clks(input int unsigned n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  task automatic send_start();
    wait_clks(HalfScl / 2);
    sda_m = 1'b1;
    wait_clks(HalfScl / 2);
    scl = 1'b1;
    wait_clks(HalfScl);
    sda_m = 1'b0;
    wait_clks(HalfScl);
    scl = 1'b0;
    compare_value("xfer_in_progress_o", xfer, 0);
    if (xfer_open) begin
      exp_rstart++;
    end else begin
      exp_start++;
    end
    xfer_open = 1'b0;
  endtask

  task automatic send_stop();
    wait_clks(HalfScl / 2);
    sda_m = 1'b0;
    wait_clks(HalfScl / 2);
    scl = 1'b1;
    wait_clks(HalfScl);
    sda_m = 1'b1;
    wait_clks(HalfScl);
    compare_value("xfer_in_progress_o", xfer, 0);
    exp_stop++;
    xfer_open = 1'b0;
  endtask

  // SDA moves mid way through SCL low
  task automatic write_bit(input logic b);
    wait_clks(HalfScl / 2);
    sda_m = b;
    wait_clks(HalfScl / 2);
    scl = 1'b1;
    wait_clks(HalfScl);
    scl = 1'b0;
  endtask

  task automatic read_bit(output logic b);
    wait_clks(HalfScl / 2);
    sda_m = 1'b1;
    wait_clks(HalfScl / 2);
    scl = 1'b1;
    wait_clks(HalfScl / 2);
    b = sda_line;
    wait_clks(HalfScl / 2);
    scl = 1'b0;
  endtask

  task automatic write_byte(input logic [7:0] data, output logic acked);
    logic b;
    for (int i = 7; i >= 0; i--) begin
      write_bit(data[i]);
    end
    read_bit(b);
    acked = !b;
  endtask

  task automatic read_byte(output logic [7:0] data, input logic host_ack);
    logic b;
    data = '0;
    for (int i = 0; i < 8; i++) begin
      read_bit(b);
      data = {data[6:0], b};
    end
    write_bit(!host_ack);
  endtask

  task automatic send_address(input logic [7:0] addr_byte, output logic acked);
    write_byte(addr_byte, acked);
    exp_addr_valid++;
    compare_value("bus_addr_o", last_addr, addr_byte);
    compare_value("sda_i address ack", acked, expected_addr_ack(i3c_mode, addr_byte));
    compare_value("xfer_in_progress_o", xfer, expected_addr_ack(i3c_mode, addr_byte));
    xfer_open = acked;
  endtask

  task automatic load_frames(input int unsigned count, input int unsigned bad_index);
    logic [7:0] data;
    frame_q.delete();
    for (int unsigned i = 0; i < count; i++) begin
      data = 8'($urandom);
      // Odd parity T-bit that is flipped on the bad frame
      frame_q.push_back({data, (~^data) ^ (i == bad_index)});
    end
  endtask

  task automatic write_transfer(input logic [7:0] addr_byte);
    logic acked;
    logic data_ack;
    logic [2:0] res;
    send_start();
    send_address(addr_byte, acked);
    for (int i = 0; i < frame_q.size() && acked; i++) begin
      res = expected_frame(i3c_mode, addr_byte, rx_full, frame_q[i]);
      if (res[2]) begin
        exp_bytes.push_back(frame_q[i][8:1]);
      end
      if (i3c_mode) begin
        for (int b = 8; b >= 0; b--) begin
          write_bit(frame_q[i][b]);
        end
      end else begin
        write_byte(frame_q[i][8:1], data_ack);
        compare_value("sda_i data ack", data_ack, res[1]);
      end
      exp_err = exp_err || res[0];
      compare_value("err_o", err, exp_err);
    end
  endtask

  task automatic read_transfer(input int unsigned len);
    logic acked;
    logic [7:0] data;
    logic [7:0] exp_data[$];
    for (int unsigned i = 0; i < len; i++) begin
      exp_data.push_back(i < tx_model.size() ? tx_model[i] : 8'hff);
    end
    send_start();
    send_address({StaAddr, 1'b1}, acked);
    for (int unsigned i = 0; i < len; i++) begin
      read_byte(data, i != len - 1);
      compare_value("sda_i read byte", data, exp_data[i]);
    end
    exp_host_nack++;
    send_stop();
  endtask

  task automatic drain_rx();
    int unsigned waited;
    waited = 0;
    while (exp_bytes.size() != 0 && waited < 4 * HalfScl) begin
      wait_clks(1);
      waited++;
    end
    assert (exp_bytes.size() == 0)
      else report_failure("Expected RX bytes never reached the RX queue");
  endtask

  task automatic check_events();
    compare_value("bus_start_o pulses", n_start, exp_start);
    compare_value("bus_rstart_o pulses", n_rstart, exp_rstart);
    compare_value("bus_stop_o pulses", n_stop, exp_stop);
    compare_value("bus_addr_valid_o pulses", n_addr_valid, exp_addr_valid);
    compare_value("tx_host_nack_o pulses", n_host_nack, exp_host_nack);
  endtask

  // RX handshake checker against the expected byte queue
  always @(posedge clk_i) begin
    if (rst_ni && rx_wvalid && rx_wready) begin
      assert (exp_bytes.size() > 0)
        else report_failure("RX queue write seen while no byte was expected");
      compare_value("rx_queue_wdata_o", rx_wdata, exp_bytes[0]);
      void'(exp_bytes.pop_front());
    end
  end

  always @(posedge clk_i) begin
    if (rst_ni) begin
      n_start += bus_start;
      n_rstart += bus_rstart;
      n_stop += bus_stop;
      n_addr_valid += bus_addr_valid;
      n_host_nack += tx_host_nack;
      if (bus_addr_valid) begin
        last_addr = bus_addr;
      end
    end
  end

  // TX queue model and random RX stalls
  always begin
    @(posedge clk_i);
    if (rst_ni && tx_rready && tx_rvalid) begin
      void'(tx_model.pop_front());
    end
    #1;
    rx_wready = ($urandom % 4) != 0;
    tx_rvalid = tx_model.size() > 0;
    if (tx_model.size() > 0) begin
      tx_rdata = tx_model[0];
    end else begin
      tx_rdata = 8'h00;
    end
  end

  initial begin
    #(2 * TotalBits * SclPeriod);
    report_failure("Watchdog expired before the tests finished");
  end

  initial begin
    void'($urandom(26));
    scl = 1'b1;
    sda_m = 1'b1;
    i3c_mode = 1'b0;
    dyn_addr_valid = 1'b0;
    rx_full = 1'b0;
    rx_wready = 1'b0;
    tx_rvalid = 1'b0;
    tx_rdata = 8'h00;
    err_clr = 1'b0;
    rst_ni = 1'b0;
    {n_start, n_rstart, n_stop, n_addr_valid, n_host_nack} = '0;
    {exp_start, exp_rstart, exp_stop, exp_addr_valid, exp_host_nack} = '0;
    last_addr = 8'h00;
    xfer_open = 1'b0;
    exp_err = 1'b0;
    wait_clks(10);
    rst_ni = 1'b1;
    wait_clks(HalfScl);

    // I2C write to our static address
    load_frames(4, 4);
    write_transfer({StaAddr, 1'b0});
    send_stop();
    drain_rx();
    check_events();

    // I2C write to another address
    load_frames(2, 2);
    write_transfer({StaAddr ^ 7'h01, 1'b0});
    send_stop();
    drain_rx();
    check_events();

    // I2C read whose third byte comes from an empty TX queue
    tx_model.push_back(8'($urandom));
    tx_model.push_back(8'($urandom));
    wait_clks(2);
    read_transfer(3);
    compare_value("tx queue model size", tx_model.size(), 0);
    check_events();

    // Back-pressure from a full RX queue
    rx_full = 1'b1;
    load_frames(1, 1);
    write_transfer({StaAddr, 1'b0});
    send_stop();
    rx_full = 1'b0;
    drain_rx();
    check_events();

    // I3C private write with one bad parity frame
    wait_clks(HalfScl);
    i3c_mode = 1'b1;
    dyn_addr_valid = 1'b1;
    wait_clks(HalfScl);
    compare_value("err_o", err, 0);
    load_frames(4, 2);
    write_transfer({DynAddr, 1'b0});
    send_stop();
    drain_rx();
    compare_value("err_o", err, 1);
    err_clr = 1'b1;
    wait_clks(1);
    err_clr = 1'b0;
    wait_clks(1);
    exp_err = 1'b0;
    compare_value("err_o", err, 0);
    check_events();

    // Repeated START between two I2C writes
    i3c_mode = 1'b0;
    wait_clks(HalfScl);
    load_frames(1, 1);
    write_transfer({StaAddr, 1'b0});
    load_frames(1, 1);
    write_transfer({StaAddr, 1'b0});
    send_stop();
    drain_rx();
    check_events();

    wait_clks(HalfScl);
    assert (exp_bytes.size() == 0 && tx_model.size() == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      report_failure("Expected RX bytes or TX model bytes left over at the end");
    end
  end

endmodule

/* filelist.f */
verilog/standby_pkg.sv
verilog/bus_monitor.sv
verilog/i2c_target.sv
verilog/i3c_target.sv
verilog/controller_standby.sv
dv/controller_standby_assertions.sv
dv/tb_controller_standby.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_controller_standby
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0
RUN_ARGS ?=

SIM := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)
